// ==== Makefile ====
TOP := mfBankTb

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	verilator --binary --timing --assert -Wno-fatal -f mfBank.f \
		--top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "=== PASS ==="

clean:
	rm -rf obj_dir

// ==== design/accBus.sv ====
// accumulator bus, execute to result
`default_nettype none
`timescale 1ns/100ps

interface accBus;
   import mfPkg::*;

   // full precision sums, x*c
   accT  mf0I;
   accT  mf0Q;
   // x*conj(c)
   accT  mf1I;
   accT  mf1Q;
   // one cycle pulse, sums valid with it
   logic done;

   // accumulator side
   modport mac (output mf0I, mf0Q, mf1I, mf1Q, done);

   // saturation and handshake side
   modport res (input mf0I, mf0Q, mf1I, mf1Q, done);

endinterface

`default_nettype wire

// ==== design/complexMac.sv ====
// complex multiply-accumulate
// mf0 with c, mf1 with conj(c)
`default_nettype none
`timescale 1ns/100ps

module complexMac (
   input logic clk,
   input logic reset,
   tapBus.mac  taps,
   accBus.mac  sums
);
   import mfPkg::*;

   // real products, one tap per clock
   prodT prodRR;
   prodT prodII;
   prodT prodIR;
   prodT prodRI;
   // tap qualifiers, delayed with the products
   logic prodValid;
   logic prodFirst;
   logic prodLast;
   // per tap terms and running sums
   // index 0 mf0I, 1 mf0Q, 2 mf1I, 3 mf1Q
   accT  term [4];
   accT  acc  [4];

   //--------------------------------------------------------------------------
   // stage 1, products
   //--------------------------------------------------------------------------
   // dataRe*coefRe
   // dataIm*coefIm
   // dataIm*coefRe
   // dataRe*coefIm
   always_ff @(posedge clk) begin
      prodRR <= prodT'(taps.dataRe) * prodT'(taps.coefRe);
      prodII <= prodT'(taps.dataIm) * prodT'(taps.coefIm);
      prodIR <= prodT'(taps.dataIm) * prodT'(taps.coefRe);
      prodRI <= prodT'(taps.dataRe) * prodT'(taps.coefIm);
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         prodValid <= 1'b0;
         prodFirst <= 1'b0;
         prodLast  <= 1'b0;
      end else begin
         prodValid <= taps.tapValid;
         prodFirst <= taps.tapValid && taps.firstTap;
         prodLast  <= taps.tapValid && taps.lastTap;
      end
   end

   //--------------------------------------------------------------------------
   // stage 2, combine and accumulate
   //--------------------------------------------------------------------------
   // x*c, real part
   assign term[0] = accT'(prodRR) - accT'(prodII);
   // x*c, imag part
   assign term[1] = accT'(prodIR) + accT'(prodRI);
   // x*conj(c) flips the sign of the coefficient imag part
   assign term[2] = accT'(prodRR) + accT'(prodII);
   assign term[3] = accT'(prodIR) - accT'(prodRI);

   // first tap loads, the rest add
   // no hold between symbols, next first tap overwrites
   always_ff @(posedge clk) begin
      if (prodValid) begin
         for (int k = 0; k < 4; k++) begin
            if (prodFirst)
               acc[k] <= term[k];
            else
               acc[k] <= acc[k] + term[k];
         end
      end
   end

   // lands with the last accumulate
   always_ff @(posedge clk) begin
      if (reset)
         sums.done <= 1'b0;
      else
         sums.done <= prodValid && prodLast;
   end

   // sums stay until the next symbol's first tap
   assign sums.mf0I = acc[0];
   assign sums.mf0Q = acc[1];
   assign sums.mf1I = acc[2];
   assign sums.mf1Q = acc[3];

endmodule

`default_nettype wire

// ==== design/mfBank.sv ====
// dual matched filter bank, top level
`default_nettype none
`timescale 1ns/100ps

module mfBank (
   input  logic          clk,
   input  logic          reset,
   // sample strobes
   input  logic          sym2xEn,
   input  logic          symEn,
   // modulation index select, taken at symEn
   input  logic          hSel,
   input  mfPkg::sampleT i,
   input  mfPkg::sampleT q,
   // consumer side
   input  logic          ack,
   output mfPkg::mfOutT  mf0I,
   output mfPkg::mfOutT  mf0Q,
   output mfPkg::mfOutT  mf1I,
   output mfPkg::mfOutT  mf1Q,
   output logic          req,
   output logic          overrun
);

   // decode to execute
   tapBus tapIf ();
   // execute to result
   accBus accIf ();

   // window capture and tap issue, taps in cycles 1 to 4
   tapSequencer tapSequencer_i (
      .clk     (clk),
      .reset   (reset),
      .sym2xEn (sym2xEn),
      .symEn   (symEn),
      .hSel    (hSel),
      .i       (i),
      .q       (q),
      .taps    (tapIf.seq)
   );

   // products and sums, done in cycle 6
   complexMac complexMac_i (
      .clk   (clk),
      .reset (reset),
      .taps  (tapIf.mac),
      .sums  (accIf.mac)
   );

   // saturated outputs, req in cycle 7
   mfResult mfResult_i (
      .clk     (clk),
      .reset   (reset),
      .ack     (ack),
      .sums    (accIf.res),
      .mf0I    (mf0I),
      .mf0Q    (mf0Q),
      .mf1I    (mf1I),
      .mf1Q    (mf1Q),
      .req     (req),
      .overrun (overrun)
   );

endmodule

`default_nettype wire

// ==== design/mfPkg.sv ====
// matched filter bank
// shared widths and coefficient banks
`default_nettype none

package mfPkg;

   //--------------------------------------------------------------------------
   // datapath widths
   //--------------------------------------------------------------------------
   // input sample, i or q
   typedef logic signed [17:0] sampleT;
   // coefficient, 1.0 = 2^17
   typedef logic signed [17:0] coefT;
   // one sample times one coefficient
   typedef logic signed [35:0] prodT;
   // four taps of two products, with headroom
   typedef logic signed [37:0] accT;
   // saturated filter output
   typedef logic signed [9:0]  mfOutT;
   // tap counter
   typedef logic [1:0]         tapIdxT;

   localparam int NUM_TAPS  = 4;
   localparam int NUM_BANKS = 2;

   //--------------------------------------------------------------------------
   // coefficient banks, [bank][tap]
   //--------------------------------------------------------------------------
   // bank 0 for the first modulation index, bank 1 for the second
   // tap 0 meets the oldest sample of the window
   localparam coefT COEF_RE [NUM_BANKS][NUM_TAPS] = '{
      '{18'sd32768, 18'sd104858, 18'sd98304, 18'sd26214},
      '{18'sd19661, 18'sd81920, 18'sd117965, 18'sd52429}
   };
   localparam coefT COEF_IM [NUM_BANKS][NUM_TAPS] = '{
      '{-18'sd45875, -18'sd19661, 18'sd22938, 18'sd39322},
      '{-18'sd58982, -18'sd36045, 18'sd9830, 18'sd49152}
   };

   // output slice starts here, top of slice is bit 34
   localparam int OUT_LSB = 25;
   // symmetric saturation limits
   localparam mfOutT OUT_MAX = 10'sd511;
   localparam mfOutT OUT_MIN = -10'sd511;

endpackage

`default_nettype wire

// ==== design/mfResult.sv ====
// result stage
// saturation, req/ack handshake, overrun
`default_nettype none
`timescale 1ns/100ps

module mfResult (
   input  logic         clk,
   input  logic         reset,
   input  logic         ack,
   accBus.res           sums,
   output mfPkg::mfOutT mf0I,
   output mfPkg::mfOutT mf0Q,
   output mfPkg::mfOutT mf1I,
   output mfPkg::mfOutT mf1Q,
   output logic         req,
   output logic         overrun
);
   import mfPkg::*;

   typedef enum logic [1:0] {HS_IDLE, HS_REQ, HS_RELEASE} hsStateT;

   hsStateT hsState;
   logic    accept;

   // top guard bits all equal, keep bits 34:25
   // otherwise clip by sign
   function automatic mfOutT satSlice(input accT sum);
      logic [$bits(accT)-OUT_LSB-$bits(mfOutT):0] guard;
      guard = sum[$bits(accT)-1:OUT_LSB+$bits(mfOutT)-1];
      if ((&guard) || !(|guard))
         return sum[OUT_LSB+$bits(mfOutT)-1:OUT_LSB];
      else if (sum[$bits(accT)-1])
         return OUT_MIN;
      else
         return OUT_MAX;
   endfunction

   // only a fully idle handshake takes a result
   assign accept = sums.done && (hsState == HS_IDLE);

   //--------------------------------------------------------------------------
   // output registers
   //--------------------------------------------------------------------------
   // held for the whole handshake, dropped results never load
   always_ff @(posedge clk) begin
      if (reset) begin
         mf0I <= '0;
         mf0Q <= '0;
         mf1I <= '0;
         mf1Q <= '0;
      end else if (accept) begin
         mf0I <= satSlice(sums.mf0I);
         mf0Q <= satSlice(sums.mf0Q);
         mf1I <= satSlice(sums.mf1I);
         mf1Q <= satSlice(sums.mf1Q);
      end
   end

   //--------------------------------------------------------------------------
   // four-phase handshake
   //--------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         hsState <= HS_IDLE;
      end else begin
         case (hsState)
            // data loads in the same edge req rises
            HS_IDLE:
               if (accept)
                  hsState <= HS_REQ;
            // wait for ack high
            HS_REQ:
               if (ack)
                  hsState <= HS_RELEASE;
            // req low, wait for ack low
            HS_RELEASE:
               if (!ack)
                  hsState <= HS_IDLE;
            default: hsState <= HS_IDLE;
         endcase
      end
   end

   assign req = (hsState == HS_REQ);

   // sticky until reset
   always_ff @(posedge clk) begin
      if (reset)
         overrun <= 1'b0;
      else if (sums.done && !accept)
         overrun <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== design/tapBus.sv ====
// tap bus, decode to execute
`default_nettype none
`timescale 1ns/100ps

interface tapBus;
   import mfPkg::*;

   // one complex coefficient per clock
   coefT   coefRe;
   coefT   coefIm;
   // matching window sample
   sampleT dataRe;
   sampleT dataIm;
   // tap qualifiers
   logic   tapValid;
   // first tap restarts the sums
   logic   firstTap;
   // last tap closes the symbol
   logic   lastTap;

   // sequencer side
   modport seq (output coefRe, coefIm, dataRe, dataIm, tapValid, firstTap, lastTap);

   // multiply-accumulate side
   modport mac (input coefRe, coefIm, dataRe, dataIm, tapValid, firstTap, lastTap);

endinterface

`default_nettype wire

// ==== design/tapSequencer.sv ====
// tap sequencer
// sample line, window capture and tap issue
`default_nettype none
`timescale 1ns/100ps

module tapSequencer (
   input  logic          clk,
   input  logic          reset,
   input  logic          sym2xEn,
   input  logic          symEn,
   input  logic          hSel,
   input  mfPkg::sampleT i,
   input  mfPkg::sampleT q,
   tapBus.seq            taps
);
   import mfPkg::*;

   typedef enum logic {SEQ_IDLE, SEQ_TAPS} seqStateT;

   seqStateT seqState;
   tapIdxT   tapIdx;
   logic     bankSel;
   logic     startWin;
   logic     issuing;
   // line, index 0 is newest
   sampleT   lineRe [NUM_TAPS];
   sampleT   lineIm [NUM_TAPS];
   // window, index 0 is oldest
   sampleT   winRe  [NUM_TAPS];
   sampleT   winIm  [NUM_TAPS];

   // symEn while busy is dropped
   assign startWin = symEn && (seqState == SEQ_IDLE);
   assign issuing  = (seqState == SEQ_TAPS);

   //--------------------------------------------------------------------------
   // sample line at twice the symbol rate
   //--------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int k = 0; k < NUM_TAPS; k++) begin
            lineRe[k] <= '0;
            lineIm[k] <= '0;
         end
      end else if (sym2xEn) begin
         lineRe[0] <= i;
         lineIm[0] <= q;
         for (int k = 1; k < NUM_TAPS; k++) begin
            lineRe[k] <= lineRe[k-1];
            lineIm[k] <= lineIm[k-1];
         end
      end
   end

   // window takes the line before this cycle's shift
   // reversed so tap 0 gets the oldest sample
   always_ff @(posedge clk) begin
      if (startWin) begin
         bankSel <= hSel;
         for (int k = 0; k < NUM_TAPS; k++) begin
            winRe[k] <= lineRe[NUM_TAPS-1-k];
            winIm[k] <= lineIm[NUM_TAPS-1-k];
         end
      end
   end

   //--------------------------------------------------------------------------
   // four tap walk
   //--------------------------------------------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         seqState <= SEQ_IDLE;
         tapIdx   <= '0;
      end else begin
         case (seqState)
            SEQ_IDLE: begin
               tapIdx <= '0;
               if (startWin)
                  seqState <= SEQ_TAPS;
            end
            SEQ_TAPS: begin
               // wraps to 0 after the last tap
               tapIdx <= tapIdx + 1'b1;
               if (tapIdx == tapIdxT'(NUM_TAPS - 1))
                  seqState <= SEQ_IDLE;
            end
            default: seqState <= SEQ_IDLE;
         endcase
      end
   end

   // qualifiers, registered with the payload below
   always_ff @(posedge clk) begin
      if (reset) begin
         taps.tapValid <= 1'b0;
         taps.firstTap <= 1'b0;
         taps.lastTap  <= 1'b0;
      end else begin
         taps.tapValid <= issuing;
         taps.firstTap <= issuing && (tapIdx == '0);
         taps.lastTap  <= issuing && (tapIdx == tapIdxT'(NUM_TAPS - 1));
      end
   end

   // coefficient from the latched bank, sample from the window
   always_ff @(posedge clk) begin
      taps.coefRe <= COEF_RE[bankSel][tapIdx];
      taps.coefIm <= COEF_IM[bankSel][tapIdx];
      taps.dataRe <= winRe[tapIdx];
      taps.dataIm <= winIm[tapIdx];
   end

endmodule

`default_nettype wire

// ==== mfBank.f ====
design/mfPkg.sv
design/tapBus.sv
design/accBus.sv
design/tapSequencer.sv
design/complexMac.sv
design/mfResult.sv
design/mfBank.sv
testbench/mfBankAsserts.sv
testbench/mfBankTb.sv

// ==== testbench/mfBankAsserts.sv ====
// result stage handshake checks
`default_nettype none
`timescale 1ns/100ps

module mfBankAsserts (
   input logic         clk,
   input logic         reset,
   input logic         ack,
   input logic         done,
   input logic         req,
   input logic         overrun,
   input mfPkg::mfOutT mf0I,
   input mfPkg::mfOutT mf0Q,
   input mfPkg::mfOutT mf1I,
   input mfPkg::mfOutT mf1Q
);

   // req already dropped and ack not yet seen low
   logic ackWait;

   always_ff @(posedge clk) begin
      if (reset)
         ackWait <= 1'b0;
      else if (req && ack)
         ackWait <= 1'b1;
      else if (!ack)
         ackWait <= 1'b0;
   end

   // req stays up until ack is seen
   reqHold: assert property (@(posedge clk) disable iff (reset)
      req && !ack |=> req)
      else $error("req dropped before ack");

   // data frozen while req is up
   dataStable: assert property (@(posedge clk) disable iff (reset)
      req |=> $stable({mf0I, mf0Q, mf1I, mf1Q}))
      else $error("outputs changed during the handshake");

   // no new req until ack has gone low
   reqAfterAckLow: assert property (@(posedge clk) disable iff (reset)
      $rose(req) |-> !$past(ack))
      else $error("req rose while ack was still high");

   // done on an idle handshake raises req one cycle later
   reqFromDone: assert property (@(posedge clk) disable iff (reset)
      done && !req && !ackWait |=> $rose(req))
      else $error("req did not follow a done on an idle handshake");

   // req never rises without a done
   reqOnlyFromDone: assert property (@(posedge clk) disable iff (reset)
      $rose(req) |-> $past(done))
      else $error("req rose without a done");

   // done on a busy handshake is dropped and flagged
   dropFlagged: assert property (@(posedge clk) disable iff (reset)
      done && (req || ackWait) |=> overrun && $stable({mf0I, mf0Q, mf1I, mf1Q}))
      else $error("busy handshake took a result or did not flag overrun");

endmodule

bind mfResult mfBankAsserts mfBankAsserts_i (
   .clk     (clk),
   .reset   (reset),
   .ack     (ack),
   .done    (sums.done),
   .req     (req),
   .overrun (overrun),
   .mf0I    (mf0I),
   .mf0Q    (mf0Q),
   .mf1I    (mf1I),
   .mf1Q    (mf1Q)
);

`default_nettype wire

// ==== testbench/mfBankTb.sv ====
// matched filter bank testbench
`default_nettype none
`timescale 1ns/100ps

module mfBankTb;
   import mfPkg::*;

   // about 40 symbols of 12 cycles plus reset, five times over
   localparam int     TIMEOUT_CYCLES = 3000;
   localparam int     LATENCY        = 7;
   localparam sampleT FULL_SCALE     = 18'sd131071;

   logic   clk;
   logic   reset;
   logic   sym2xEn;
   logic   symEn;
   logic   hSel;
   sampleT iData;
   sampleT qData;
   logic   ack;
   mfOutT  mf0I;
   mfOutT  mf0Q;
   mfOutT  mf1I;
   mfOutT  mf1Q;
   logic   req;
   logic   overrun;

   int          errors = 0;
   int          checks = 0;
   int          cycles = 0;
   logic [31:0] rngState;
   // window to send, index 0 oldest
   sampleT      winRe [NUM_TAPS];
   sampleT      winIm [NUM_TAPS];
   // model outputs, order mf0I mf0Q mf1I mf1Q
   mfOutT       expOut [4];

   mfBank mfBank_i (
      .clk (clk), .reset (reset), .sym2xEn (sym2xEn), .symEn (symEn),
      .hSel (hSel), .i (iData), .q (qData), .ack (ack),
      .mf0I (mf0I), .mf0Q (mf0Q), .mf1I (mf1I), .mf1Q (mf1Q),
      .req (req), .overrun (overrun)
   );

   initial clk = 1'b0;
   always #4 clk = ~clk;

   // run limit
   always @(posedge clk) begin
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("run stopped after %0d cycles without finishing, errors %0d", cycles, errors);
         $display("=== FAIL ===");
         $finish;
      end
   end

   //--------------------------------------------------------------------------
   // reference model
   //--------------------------------------------------------------------------
   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic sampleT nextSample();
      rngState = xorshift(rngState);
      return sampleT'(rngState[17:0]);
   endfunction

   // keep bits 34:25 when bits 37:34 agree, else clip by sign
   function automatic mfOutT outRule(input longint sum);
      logic signed [37:0] a;
      a = sum[37:0];
      if (a[37:34] == 4'b0000 || a[37:34] == 4'b1111)
         return a[34:25];
      else if (a[37])
         return OUT_MIN;
      else
         return OUT_MAX;
   endfunction

   // x*c into mf0, x*conj(c) into mf1
   task automatic modelSymbol(input logic bank);
      longint s [4];
      longint xr;
      longint xi;
      longint cr;
      longint ci;
      for (int k = 0; k < 4; k++)
         s[k] = 0;
      for (int k = 0; k < NUM_TAPS; k++) begin
         xr = winRe[k];
         xi = winIm[k];
         cr = COEF_RE[bank][k];
         ci = COEF_IM[bank][k];
         s[0] += xr * cr - xi * ci;
         s[1] += xi * cr + xr * ci;
         s[2] += xr * cr + xi * ci;
         s[3] += xi * cr - xr * ci;
      end
      for (int k = 0; k < 4; k++)
         expOut[k] = outRule(s[k]);
   endtask

   //--------------------------------------------------------------------------
   // drive and check helpers
   //--------------------------------------------------------------------------
   task automatic checkValue(input string name, input mfOutT actual, input mfOutT expected);
      checks++;
      assert (actual == expected) else begin
         errors++;
         $display("FAILED t=%0t %s expected %0d got %0d", $time, name, expected, actual);
      end
   endtask

   task automatic checkBit(input string name, input logic actual, input logic expected);
      checks++;
      assert (actual == expected) else begin
         errors++;
         $display("FAILED t=%0t %s expected %0b got %0b", $time, name, expected, actual);
      end
   endtask

   task automatic checkOutputs();
      checkValue("mf0I", mf0I, expOut[0]);
      checkValue("mf0Q", mf0Q, expOut[1]);
      checkValue("mf1I", mf1I, expOut[2]);
      checkValue("mf1Q", mf1Q, expOut[3]);
   endtask

   // oldest sample first, then symEn alone
   task automatic sendSymbol(input logic bank);
      for (int k = 0; k < NUM_TAPS; k++) begin
         @(negedge clk);
         sym2xEn = 1'b1;
         iData   = winRe[k];
         qData   = winIm[k];
      end
      @(negedge clk);
      sym2xEn = 1'b0;
      symEn   = 1'b1;
      hSel    = bank;
      @(negedge clk);
      symEn   = 1'b0;
   endtask

   // counts edges after the symEn edge
   task automatic waitReq(output int lat);
      lat = 0;
      while (!req && lat < 20) begin
         @(negedge clk);
         lat++;
      end
      checks++;
      assert (req) else begin
         errors++;
         $display("req never rose after symEn, t=%0t", $time);
      end
   endtask

   task automatic finishHandshake();
      int n;
      n   = 0;
      ack = 1'b1;
      while (req && n < 20) begin
         @(negedge clk);
         n++;
      end
      checks++;
      assert (!req) else begin
         errors++;
         $display("req stayed high after ack, t=%0t", $time);
      end
      ack = 1'b0;
      repeat (2) @(negedge clk);
   endtask

   task automatic fillRandom();
      for (int k = 0; k < NUM_TAPS; k++) begin
         winRe[k] = nextSample();
         winIm[k] = nextSample();
      end
   endtask

   // one symbol with a prompt ack
   task automatic symbolRound(input logic bank);
      int lat;
      modelSymbol(bank);
      sendSymbol(bank);
      waitReq(lat);
      if (req) begin
         checks++;
         assert (lat == LATENCY) else begin
            errors++;
            $display("FAILED t=%0t req latency expected %0d got %0d", $time, LATENCY, lat);
         end
         checkOutputs();
      end
      finishHandshake();
   endtask

   //--------------------------------------------------------------------------
   // directed tests
   //--------------------------------------------------------------------------
   task automatic resetTest();
      for (int k = 0; k < 4; k++)
         expOut[k] = '0;
      checkBit("req", req, 1'b0);
      checkBit("overrun", overrun, 1'b0);
      checkOutputs();
   endtask

   // one nonzero sample walked over the taps
   task automatic impulseTest(input logic bank);
      for (int p = 0; p < NUM_TAPS; p++) begin
         for (int k = 0; k < NUM_TAPS; k++) begin
            winRe[k] = (k == p) ? 18'sd60000 : 18'sd0;
            winIm[k] = (k == p) ? -18'sd30000 : 18'sd0;
         end
         symbolRound(bank);
      end
   endtask

   // bank flips every symbol
   task automatic alternateTest();
      for (int n = 0; n < 4; n++) begin
         fillRandom();
         symbolRound(n[0]);
      end
   endtask

   task automatic randomTest();
      for (int n = 0; n < 20; n++) begin
         fillRandom();
         symbolRound(rngState[20]);
      end
      checkBit("overrun", overrun, 1'b0);
   endtask

   // signs lined up with bank 0, then the negated window
   task automatic saturationTest();
      logic sawMax;
      logic sawMin;
      sawMax = 1'b0;
      sawMin = 1'b0;
      for (int pol = 0; pol < 2; pol++) begin
         for (int k = 0; k < NUM_TAPS; k++) begin
            winRe[k] = ((COEF_RE[0][k] < 0) ^ pol[0]) ? -FULL_SCALE : FULL_SCALE;
            winIm[k] = ((COEF_IM[0][k] < 0) ^ pol[0]) ? FULL_SCALE : -FULL_SCALE;
         end
         symbolRound(1'b0);
         if (mf0I == OUT_MAX || mf0Q == OUT_MAX || mf1I == OUT_MAX || mf1Q == OUT_MAX)
            sawMax = 1'b1;
         if (mf0I == OUT_MIN || mf0Q == OUT_MIN || mf1I == OUT_MIN || mf1Q == OUT_MIN)
            sawMin = 1'b1;
      end
      checks++;
      assert (sawMax && sawMin) else begin
         errors++;
         $display("full-scale input did not reach both saturation limits");
      end
   endtask

   // second symbol lands while the first is unacknowledged
   task automatic backpressureTest();
      int lat;
      int n;
      fillRandom();
      modelSymbol(1'b0);
      sendSymbol(1'b0);
      waitReq(lat);
      checkOutputs();
      fillRandom();
      sendSymbol(1'b1);
      n = 0;
      while (!overrun && n < 20) begin
         @(negedge clk);
         n++;
      end
      checks++;
      assert (overrun && req) else begin
         errors++;
         $display("overrun did not rise, or req fell, while ack was withheld");
      end
      // first result still held
      checkOutputs();
      finishHandshake();
      checkOutputs();
      fillRandom();
      symbolRound(1'b0);
      checkBit("overrun", overrun, 1'b1);
   endtask

   initial begin
      rngState = 32'd81513;
      reset    = 1'b1;
      sym2xEn  = 1'b0;
      symEn    = 1'b0;
      hSel     = 1'b0;
      iData    = '0;
      qData    = '0;
      ack      = 1'b0;
      repeat (8) @(posedge clk);
      @(negedge clk);
      reset = 1'b0;
      @(negedge clk);
      resetTest();
      impulseTest(1'b0);
      impulseTest(1'b1);
      alternateTest();
      randomTest();
      saturationTest();
      backpressureTest();
      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

`default_nettype wire
